// ==== hdl/hid_pkg.sv ====
package hid_pkg;

    // device type as reported on typ
    typedef enum logic [1:0] {
        DEV_NONE     = 2'd0,
        DEV_KEYBOARD = 2'd1,
        DEV_MOUSE    = 2'd2,
        DEV_GAMEPAD  = 2'd3
    } dev_type_t;

    // byte channel payload
    typedef struct packed {
        logic [7:0] data;
        logic       last;   // final byte of the frame
    } hid_byte_t;

    // per-byte event towards the decoders
    typedef struct packed {
        logic       valid;  // one-cycle strobe
        logic [3:0] index;  // position within frame, saturates at 15
        logic [7:0] data;
    } byte_evt_t;

    // descriptor field codes
    localparam logic [1:0] FLD_CLASS    = 2'd0;
    localparam logic [1:0] FLD_SUBCLASS = 2'd1;
    localparam logic [1:0] FLD_PROTOCOL = 2'd2;

    typedef struct packed {
        logic [1:0] field;
        logic [7:0] value;
    } desc_field_t;

    typedef struct packed {
        logic [7:0] modifiers;
        logic [7:0] key1;
        logic [7:0] key2;
        logic [7:0] key3;
        logic [7:0] key4;
    } kbd_report_t;

    typedef struct packed {
        logic [7:0]        btn;  // {5'bx, middle, right, left}
        logic signed [7:0] dx;
        logic signed [7:0] dy;
    } mouse_report_t;

    typedef struct packed {
        logic l, r, u, d;
        logic a, b, x, y;
        logic sel, sta, lb, rb;
        logic [11:0] snes;   // rb lb x a r l d u sta sel y b
    } gamepad_t;

    localparam int          REPORT_BYTES  = 8;
    localparam logic [7:0]  HID_CLASS     = 8'd3;
    localparam logic [7:0]  BOOT_SUBCLASS = 8'd1;
    localparam logic [7:0]  KBD_PROTOCOL  = 8'd1;
    localparam logic [1:0]  DS2_SKIP_TAG  = 2'b10;

    // roughly one second at 12 MHz
    localparam logic [23:0] CONN_TIMEOUT_DEFAULT = 24'd12_582_912;

endpackage

// ==== hdl/hid_frame_rx.sv ====
`timescale 1ns/100ps

module hid_frame_rx #(
    parameter logic [23:0] conn_timeout = hid_pkg::CONN_TIMEOUT_DEFAULT
) (
    input  logic                usbclk,
    input  logic                usbrst_n,
    input  logic                connected,
    input  logic                byte_req,
    input  hid_pkg::hid_byte_t  byte_in,
    input  hid_pkg::dev_type_t  typ,
    output logic                byte_ack,
    output hid_pkg::byte_evt_t  byte_evt,
    output logic                report,
    output logic                conerr,
    output logic [63:0]         dbg_hid_report
);

    logic        accept;
    logic [3:0]  idx;          // position of the next byte
    logic        last_evt;     // event of a last byte this cycle
    logic        report_end;
    logic [7:0]  dat [hid_pkg::REPORT_BYTES];
    logic [23:0] conn_cnt;

    assign accept = byte_req && !byte_ack;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            byte_ack   <= 1'b0;
            byte_evt   <= '0;
            idx        <= 4'd0;
            last_evt   <= 1'b0;
            report_end <= 1'b0;
            report     <= 1'b0;
        end else begin
            byte_evt.valid <= accept;
            last_evt       <= accept && byte_in.last;
            report_end     <= last_evt;
            report         <= report_end && (typ != hid_pkg::DEV_NONE);
            if (accept) begin
                byte_ack       <= 1'b1;
                byte_evt.index <= idx;
                byte_evt.data  <= byte_in.data;
                if (byte_in.last)
                    idx <= 4'd0;           // next frame starts over
                else if (idx != 4'd15)
                    idx <= idx + 4'd1;
            end else if (!byte_req) begin
                byte_ack <= 1'b0;
            end
        end
    end

    // first eight bytes of the frame
    always_ff @(posedge usbclk) begin
        if (accept && idx < hid_pkg::REPORT_BYTES)
            dat[idx[2:0]] <= byte_in.data;
    end

    always_comb begin
        for (int i = 0; i < hid_pkg::REPORT_BYTES; i++)
            dbg_hid_report[i*8 +: 8] = dat[i];   // byte 0 in the low bits
    end

    // connection watchdog
    always_ff @(posedge usbclk) begin
        if (!usbrst_n || !connected || accept) begin
            conn_cnt <= 24'd0;
            conerr   <= 1'b0;
        end else if (conn_cnt == conn_timeout) begin
            conerr <= 1'b1;   // hold until traffic resumes
        end else begin
            conn_cnt <= conn_cnt + 24'd1;
        end
    end

    ack_needs_req: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $rose(byte_ack) |-> $past(byte_req))
        else $error("byte_ack rose without byte_req");

    report_single: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report |=> !report)
        else $error("report held for two cycles");

endmodule

// ==== hdl/hid_class_detect.sv ====
`timescale 1ns/100ps

module hid_class_detect (
    input  logic                  usbclk,
    input  logic                  usbrst_n,
    input  logic                  connected,
    input  logic                  desc_req,
    input  hid_pkg::desc_field_t  desc_in,
    output logic                  desc_ack,
    output hid_pkg::dev_type_t    typ
);

    logic       accept;
    logic       proto_seen;   // protocol field landed last cycle
    logic       connected_r;
    logic [7:0] cls;
    logic [7:0] subcls;
    logic [7:0] proto;

    assign accept = desc_req && !desc_ack;

    // descriptor field registers
    always_ff @(posedge usbclk) begin
        if (accept) begin
            case (desc_in.field)
                hid_pkg::FLD_CLASS:    cls    <= desc_in.value;
                hid_pkg::FLD_SUBCLASS: subcls <= desc_in.value;
                hid_pkg::FLD_PROTOCOL: proto  <= desc_in.value;
                default: ;   // unknown code, dropped
            endcase
        end
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            desc_ack    <= 1'b0;
            proto_seen  <= 1'b0;
            connected_r <= 1'b0;
            typ         <= hid_pkg::DEV_NONE;
        end else begin
            connected_r <= connected;
            proto_seen  <= accept && (desc_in.field == hid_pkg::FLD_PROTOCOL);
            if (accept)
                desc_ack <= 1'b1;
            else if (!desc_req)
                desc_ack <= 1'b0;

            if (proto_seen) begin
                if (cls != hid_pkg::HID_CLASS)
                    typ <= hid_pkg::DEV_NONE;
                else if (subcls != hid_pkg::BOOT_SUBCLASS)
                    typ <= hid_pkg::DEV_GAMEPAD;   // non-boot hid
                else if (proto == hid_pkg::KBD_PROTOCOL)
                    typ <= hid_pkg::DEV_KEYBOARD;
                else
                    typ <= hid_pkg::DEV_MOUSE;
            end
            if (!connected && connected_r)
                typ <= hid_pkg::DEV_NONE;   // device unplugged
        end
    end

    desc_ack_needs_req: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $rose(desc_ack) |-> $past(desc_req))
        else $error("desc_ack rose without desc_req");

endmodule

// ==== hdl/hid_boot_decode.sv ====
`timescale 1ns/100ps

module hid_boot_decode (
    input  logic                   usbclk,
    input  logic                   usbrst_n,
    input  hid_pkg::dev_type_t     typ,
    input  hid_pkg::byte_evt_t     byte_evt,
    input  logic                   report,
    output hid_pkg::kbd_report_t   kbd,
    output hid_pkg::mouse_report_t mouse
);

    logic kbd_evt;
    logic mouse_evt;

    assign kbd_evt   = byte_evt.valid && (typ == hid_pkg::DEV_KEYBOARD);
    assign mouse_evt = byte_evt.valid && (typ == hid_pkg::DEV_MOUSE);

    // boot keyboard: byte 1 is reserved
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            kbd <= '0;
        end else if (kbd_evt) begin
            case (byte_evt.index)
                4'd0: kbd.modifiers <= byte_evt.data;
                4'd2: kbd.key1      <= byte_evt.data;
                4'd3: kbd.key2      <= byte_evt.data;
                4'd4: kbd.key3      <= byte_evt.data;
                4'd5: kbd.key4      <= byte_evt.data;
                default: ;
            endcase
        end
    end

    // boot mouse
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            mouse <= '0;
        end else begin
            if (report) begin
                // motion is relative, so no bytes means no motion
                mouse.dx <= '0;
                mouse.dy <= '0;
            end
            if (mouse_evt) begin
                case (byte_evt.index)
                    4'd0: mouse.btn <= byte_evt.data;
                    4'd1: mouse.dx  <= byte_evt.data;   // wins over the clear
                    4'd2: mouse.dy  <= byte_evt.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/hid_gamepad_decode.sv ====
`timescale 1ns/100ps

module hid_gamepad_decode (
    input  logic               usbclk,
    input  logic               usbrst_n,
    input  hid_pkg::dev_type_t typ,
    input  hid_pkg::byte_evt_t byte_evt,
    output hid_pkg::gamepad_t  game
);

    hid_pkg::gamepad_t pad_q;
    hid_pkg::gamepad_t pad_d;
    logic              valid_q;   // current record is not a skip record
    logic              valid_d;

    // {neg, pos} of one axis, unchanged when the value is centred
    function automatic logic [1:0] axis_set(input logic neg, input logic pos,
                                            input logic [1:0] cur);
        if (neg)
            return 2'b10;
        else if (pos)
            return 2'b01;
        else
            return cur;
    endfunction

    always_comb begin
        pad_d   = pad_q;
        valid_d = valid_q;
        if (byte_evt.valid && typ == hid_pkg::DEV_GAMEPAD) begin
            case (byte_evt.index)
                4'd0: begin
                    valid_d = (byte_evt.data[1:0] != hid_pkg::DS2_SKIP_TAG);
                    if (valid_d)
                        {pad_d.l, pad_d.r, pad_d.u, pad_d.d} = 4'b0000;
                    {pad_d.l, pad_d.r} = axis_set(byte_evt.data == 8'h00,
                                                  byte_evt.data == 8'hff,
                                                  {pad_d.l, pad_d.r});
                end
                4'd1: {pad_d.u, pad_d.d} = axis_set(byte_evt.data == 8'h00,
                                                    byte_evt.data == 8'hff,
                                                    {pad_d.u, pad_d.d});
                4'd3: if (valid_q)   // x axis, top bits only
                    {pad_d.l, pad_d.r} = axis_set(byte_evt.data[7:6] == 2'b00,
                                                  byte_evt.data[7:6] == 2'b11,
                                                  {pad_d.l, pad_d.r});
                4'd4: if (valid_q)
                    {pad_d.u, pad_d.d} = axis_set(byte_evt.data[7:6] == 2'b00,
                                                  byte_evt.data[7:6] == 2'b11,
                                                  {pad_d.u, pad_d.d});
                4'd5: if (valid_q)
                    {pad_d.y, pad_d.b, pad_d.a, pad_d.x} = byte_evt.data[7:4];
                4'd6: if (valid_q) begin
                    {pad_d.sta, pad_d.sel} = byte_evt.data[5:4];
                    {pad_d.lb, pad_d.rb}   = byte_evt.data[1:0];
                end
                default: ;
            endcase
        end
        pad_d.snes = {pad_d.rb, pad_d.lb, pad_d.x, pad_d.a, pad_d.r, pad_d.l,
                      pad_d.d, pad_d.u, pad_d.sta, pad_d.sel, pad_d.y, pad_d.b};
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            pad_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            pad_q   <= pad_d;
            valid_q <= valid_d;
        end
    end

    assign game = pad_q;

    no_left_right: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        !(game.l && game.r))
        else $error("gamepad left and right both set");

endmodule

// ==== hdl/usb_hid_host.sv ====
`timescale 1ns/100ps

module usb_hid_host #(
    parameter logic [23:0] conn_timeout = hid_pkg::CONN_TIMEOUT_DEFAULT
) (
    input  logic                   usbclk,
    input  logic                   usbrst_n,
    input  logic                   connected,
    input  logic                   byte_req,
    input  hid_pkg::hid_byte_t     byte_in,
    input  logic                   desc_req,
    input  hid_pkg::desc_field_t   desc_in,
    output logic                   byte_ack,
    output logic                   desc_ack,
    output hid_pkg::dev_type_t     typ,
    output logic                   report,   // one pulse per frame
    output logic                   conerr,
    output hid_pkg::kbd_report_t   kbd,
    output hid_pkg::mouse_report_t mouse,
    output hid_pkg::gamepad_t      game,
    output logic [63:0]            dbg_hid_report
);

    hid_pkg::byte_evt_t byte_evt;

    hid_frame_rx #(
        .conn_timeout(conn_timeout)
    ) u_frame_rx (
        .usbclk        (usbclk),
        .usbrst_n      (usbrst_n),
        .connected     (connected),
        .byte_req      (byte_req),
        .byte_in       (byte_in),
        .typ           (typ),
        .byte_ack      (byte_ack),
        .byte_evt      (byte_evt),
        .report        (report),
        .conerr        (conerr),
        .dbg_hid_report(dbg_hid_report)
    );

    hid_class_detect u_class_detect (
        .usbclk   (usbclk),
        .usbrst_n (usbrst_n),
        .connected(connected),
        .desc_req (desc_req),
        .desc_in  (desc_in),
        .desc_ack (desc_ack),
        .typ      (typ)
    );

    hid_boot_decode u_boot_decode (
        .usbclk  (usbclk),
        .usbrst_n(usbrst_n),
        .typ     (typ),
        .byte_evt(byte_evt),
        .report  (report),
        .kbd     (kbd),
        .mouse   (mouse)
    );

    hid_gamepad_decode u_gamepad_decode (
        .usbclk  (usbclk),
        .usbrst_n(usbrst_n),
        .typ     (typ),
        .byte_evt(byte_evt),
        .game    (game)
    );

endmodule

// ==== test/hid_tb_tasks.svh ====
`ifndef HID_TB_TASKS_SVH
`define HID_TB_TASKS_SVH

// idle for 0 to 3 cycles between handshake phases
task automatic random_gap();
    repeat ($urandom % 4) @(negedge usbclk);
endtask

// one four-phase transfer on the byte channel
task automatic send_byte(input logic [7:0] d, input logic last);
    @(negedge usbclk);
    random_gap();
    byte_in.data = d;
    byte_in.last = last;
    byte_req     = 1'b1;
    while (!byte_ack) @(negedge usbclk);
    random_gap();
    byte_req = 1'b0;
    while (byte_ack) @(negedge usbclk);
endtask

// one four-phase transfer on the descriptor channel
task automatic send_desc(input logic [1:0] field, input logic [7:0] value);
    @(negedge usbclk);
    random_gap();
    desc_in.field = field;
    desc_in.value = value;
    desc_req      = 1'b1;
    while (!desc_ack) @(negedge usbclk);
    random_gap();
    desc_req = 1'b0;
    while (desc_ack) @(negedge usbclk);
endtask

// class, subclass, protocol, with the expected type set up front
task automatic send_descriptor(input logic [7:0] c, input logic [7:0] s, input logic [7:0] p);
    exp_typ = expected_type(c, s, p);
    send_desc(hid_pkg::FLD_CLASS, c);
    send_desc(hid_pkg::FLD_SUBCLASS, s);
    send_desc(hid_pkg::FLD_PROTOCOL, p);
    repeat (3) @(negedge usbclk);
endtask

// sends frame[0] .. frame[n-1], last flag on the final byte
task automatic send_frame(input int n);
    for (int i = 0; i < n; i++)
        send_byte(frame[i], i == n - 1);
    repeat (4) @(negedge usbclk);   // let report and the clear pass
endtask

task automatic random_frame(input int n);
    for (int i = 0; i < n; i++)
        frame[i] = 8'($urandom);
endtask

`endif

// ==== test/tb_usb_hid_host.sv ====
`timescale 1ns/100ps

module tb_usb_hid_host;

    localparam int  RUN_CYCLES = 4000;   // frames, descriptors and the idle stretch
    localparam time RUN_LIMIT  = RUN_CYCLES * 10ns;

    logic                   usbclk;
    logic                   usbrst_n;
    logic                   connected;
    logic                   byte_req;
    hid_pkg::hid_byte_t     byte_in;
    logic                   desc_req;
    hid_pkg::desc_field_t   desc_in;
    logic                   byte_ack;
    logic                   desc_ack;
    hid_pkg::dev_type_t     typ;
    logic                   report;
    logic                   conerr;
    hid_pkg::kbd_report_t   kbd;
    hid_pkg::mouse_report_t mouse;
    hid_pkg::gamepad_t      game;
    logic [63:0]            dbg_hid_report;

    hid_pkg::dev_type_t     exp_typ;
    hid_pkg::kbd_report_t   exp_kbd;
    hid_pkg::mouse_report_t exp_mouse;
    hid_pkg::gamepad_t      exp_game;
    logic [63:0]            exp_dbg;
    logic [7:0]             frame [8];
    int                     idle_cnt;
    int                     errors;
    logic                   byte_take;
    logic                   last_take;

    usb_hid_host #(.conn_timeout(24'd300)) UUT (.*);

    always #5 usbclk = ~usbclk;

    assign byte_take = byte_req && !byte_ack;
    assign last_take = byte_take && byte_in.last && exp_typ != hid_pkg::DEV_NONE;

    // cycles with no accepted byte while connected
    always @(posedge usbclk) begin
        if (!usbrst_n || !connected || byte_take)
            idle_cnt <= 0;
        else
            idle_cnt <= idle_cnt + 1;
    end

    function automatic hid_pkg::dev_type_t expected_type(input logic [7:0] c,
                                                         input logic [7:0] s,
                                                         input logic [7:0] p);
        if (c != 8'd3)
            return hid_pkg::DEV_NONE;
        if (s != 8'd1)
            return hid_pkg::DEV_GAMEPAD;
        return (p == 8'd1) ? hid_pkg::DEV_KEYBOARD : hid_pkg::DEV_MOUSE;
    endfunction

    task automatic stop_failed(input string why);
        errors++;
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    `include "hid_tb_tasks.svh"

    reset_outputs: assert property (@(posedge usbclk)
        $rose(usbrst_n) |-> (typ == hid_pkg::DEV_NONE && !report && !byte_ack
                             && !desc_ack && !conerr))
        else stop_failed($sformatf("Fail at %0t: outputs not low after reset", $time));

    byte_ack_rise: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        byte_take |=> byte_ack)
        else stop_failed($sformatf("Fail at %0t: byte_ack late", $time));
    byte_ack_fall: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        !byte_req |=> !byte_ack)
        else stop_failed($sformatf("Fail at %0t: byte_ack held without req", $time));
    desc_ack_rise: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        desc_req && !desc_ack |=> desc_ack)
        else stop_failed($sformatf("Fail at %0t: desc_ack late", $time));
    desc_ack_fall: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        !desc_req |=> !desc_ack)
        else stop_failed($sformatf("Fail at %0t: desc_ack held without req", $time));

    typ_after_proto: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        desc_req && !desc_ack && desc_in.field == hid_pkg::FLD_PROTOCOL
        |-> ##2 typ == exp_typ)
        else stop_failed($sformatf("Fail at %0t: typ %0d, expected %0d", $time, typ, exp_typ));
    typ_on_unplug: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $fell(connected) |=> typ == hid_pkg::DEV_NONE)
        else stop_failed($sformatf("Fail at %0t: typ kept after disconnect", $time));

    report_timing: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        last_take |-> ##3 report)
        else stop_failed($sformatf("Fail at %0t: report missing", $time));
    report_cause: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report |-> $past(last_take, 3))
        else stop_failed($sformatf("Fail at %0t: unexpected report", $time));

    kbd_value: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report && typ == hid_pkg::DEV_KEYBOARD |-> kbd == exp_kbd && dbg_hid_report == exp_dbg)
        else stop_failed($sformatf("Fail at %0t: kbd %h, expected %h", $time, kbd, exp_kbd));
    mouse_value: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report && typ == hid_pkg::DEV_MOUSE |-> mouse == exp_mouse)
        else stop_failed($sformatf("Fail at %0t: mouse %h, expected %h", $time, mouse, exp_mouse));
    mouse_clear: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report && typ == hid_pkg::DEV_MOUSE |=> mouse.dx == 0 && mouse.dy == 0)
        else stop_failed($sformatf("Fail at %0t: mouse deltas not cleared", $time));
    game_value: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report && typ == hid_pkg::DEV_GAMEPAD |-> game == exp_game)
        else stop_failed($sformatf("Fail at %0t: game %h, expected %h", $time, game, exp_game));

    conerr_rise: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        idle_cnt > 305 |-> conerr)
        else stop_failed($sformatf("Fail at %0t: conerr missing", $time));
    conerr_early: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        conerr |-> idle_cnt >= 290)
        else stop_failed($sformatf("Fail at %0t: conerr too early", $time));
    conerr_clear: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        byte_take |=> !conerr)
        else stop_failed($sformatf("Fail at %0t: conerr kept after a byte", $time));

    initial begin
        #(RUN_LIMIT);
        stop_failed("Timeout: the test sequence did not finish in time");
    end

    initial begin
        void'($urandom(71));
        errors    = 0;
        usbclk    = 1'b0;
        usbrst_n  = 1'b0;
        connected = 1'b0;
        byte_req  = 1'b0;
        byte_in   = '0;
        desc_req  = 1'b0;
        desc_in   = '0;
        exp_typ   = hid_pkg::DEV_NONE;
        exp_kbd   = '0;
        exp_mouse = '0;
        exp_game  = '0;
        exp_dbg   = '0;
        repeat (2) @(negedge usbclk);
        usbrst_n  = 1'b1;
        connected = 1'b1;

        // keyboard
        send_descriptor(8'd3, 8'd1, 8'd1);
        random_frame(8);
        exp_kbd = {frame[0], frame[2], frame[3], frame[4], frame[5]};
        exp_dbg = {frame[7], frame[6], frame[5], frame[4],
                   frame[3], frame[2], frame[1], frame[0]};
        send_frame(8);

        // mouse, then a second frame to see the deltas clear again
        send_descriptor(8'd3, 8'd1, 8'd2);
        for (int k = 0; k < 2; k++) begin
            random_frame(4);
            exp_mouse = {frame[0], frame[1], frame[2]};
            send_frame(4);
        end

        // gamepad, valid record then a skip record
        send_descriptor(8'd3, 8'd0, 8'd0);
        frame = '{8'h81, 8'h80, 8'h00, 8'hc0, 8'h80, 8'h30, 8'h00, 8'h00};
        exp_game      = '0;
        exp_game.r    = 1'b1;
        exp_game.x    = 1'b1;
        exp_game.a    = 1'b1;
        exp_game.snes = 12'b0011_1000_0000;   // x, a and r set
        send_frame(8);
        frame = '{8'h82, 8'h80, 8'h00, 8'h00, 8'h80, 8'hf0, 8'h33, 8'h00};
        send_frame(8);

        // no device, then unplug a keyboard
        send_descriptor(8'd5, 8'd0, 8'd0);
        random_frame(8);
        send_frame(8);
        send_descriptor(8'd3, 8'd1, 8'd1);
        connected = 1'b0;
        exp_typ   = hid_pkg::DEV_NONE;
        repeat (3) @(negedge usbclk);
        connected = 1'b1;

        // watchdog
        repeat (320) @(negedge usbclk);
        send_byte(8'h55, 1'b1);
        repeat (4) @(negedge usbclk);

        if (errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== compile.f ====
+incdir+test
hdl/hid_pkg.sv
hdl/hid_frame_rx.sv
hdl/hid_class_detect.sv
hdl/hid_boot_decode.sv
hdl/hid_gamepad_decode.sv
hdl/usb_hid_host.sv
test/tb_usb_hid_host.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_usb_hid_host -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
